// File: compile.f
+incdir+include
rtl/stream_types_pkg.sv
rtl/fifo_types_pkg.sv
rtl/axis_skid_buffer.sv
rtl/axis_distrib.sv
rtl/axis_fifo_sync.sv
rtl/axis_broadcast_top.sv
tb/axis_broadcast_tb.sv

// File: include/stream_defs.svh
// stream broadcast parameters
// channel count, payload width and per-channel FIFO depth
// shared by the type packages and the RTL

`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

// output channels fed from the one input stream
`define STREAM_NUM_CHANNELS 4

// payload bits per word
`define STREAM_DATA_WIDTH 16

// words per channel FIFO, power of two
`define STREAM_FIFO_DEPTH 8

`endif

// File: rtl/axis_broadcast_top.sv
// stream broadcast top level
// skid buffer on the input, distributor copying each word to
// every channel, then one FIFO per channel on the output
// zero-wait latency from input transfer to outputs is 3 cycles

`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module axis_broadcast_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         s_tvalid,
  output logic                         s_tready,
  input  stream_types_pkg::data_word_t s_tdata,
  output stream_types_pkg::chan_vec_t  m_tvalid,
  input  stream_types_pkg::chan_vec_t  m_tready,
  output stream_types_pkg::data_word_t m_tdata [`STREAM_NUM_CHANNELS]
);
  import stream_types_pkg::*;

  // skid buffer to distributor
  logic       buf_tvalid;
  logic       buf_tready;
  data_word_t buf_tdata;

  // distributor to channel FIFOs
  chan_vec_t  dist_tvalid;
  chan_vec_t  dist_tready;
  data_word_t dist_tdata [`STREAM_NUM_CHANNELS];

  //////////////////////////////////////////////////
  // input and distribution
  //////////////////////////////////////////////////

  axis_skid_buffer axis_skid_buffer_i (
    .clk      (clk),
    .rst      (rst),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .m_tvalid (buf_tvalid),
    .m_tready (buf_tready),
    .m_tdata  (buf_tdata)
  );

  axis_distrib axis_distrib_i (
    .clk      (clk),
    .rst      (rst),
    .s_tvalid (buf_tvalid),
    .s_tready (buf_tready),
    .s_tdata  (buf_tdata),
    .m_tvalid (dist_tvalid),
    .m_tready (dist_tready),
    .m_tdata  (dist_tdata)
  );

  //////////////////////////////////////////////////
  // per-channel output FIFOs
  //////////////////////////////////////////////////

  for (genvar n = 0; n < `STREAM_NUM_CHANNELS; n++) begin : g_chan
    axis_fifo_sync #(
      .DEPTH (`STREAM_FIFO_DEPTH)
    ) axis_fifo_sync_i (
      .clk      (clk),
      .rst      (rst),
      .s_tvalid (dist_tvalid[n]),
      .s_tready (dist_tready[n]),
      .s_tdata  (dist_tdata[n]),
      .m_tvalid (m_tvalid[n]),
      .m_tready (m_tready[n]),
      .m_tdata  (m_tdata[n])
    );
  end

endmodule

`default_nettype wire

// File: rtl/axis_distrib.sv
// stream distributor
// copies every input word to all channels, holding the word on
// each channel until that channel takes it
// the next input word is accepted only after every channel
// has taken the current one
// one cycle latency, registered valid and data per channel

`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module axis_distrib (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         s_tvalid,
  output logic                         s_tready,
  input  stream_types_pkg::data_word_t s_tdata,
  output stream_types_pkg::chan_vec_t  m_tvalid,
  input  stream_types_pkg::chan_vec_t  m_tready,
  output stream_types_pkg::data_word_t m_tdata [`STREAM_NUM_CHANNELS]
);
  import stream_types_pkg::*;

  // delivered flags for the word on the input
  chan_vec_t ready_all;
  chan_vec_t ready_all_next;
  chan_vec_t dist_frame;
  logic      s_frame;

  //////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////

  assign s_frame = s_tvalid & s_tready;

  // delivered before, or delivering now
  assign dist_frame     = m_tvalid & m_tready;
  assign ready_all_next = ready_all | dist_frame;

  // take the word once all channels are covered
  assign s_tready = &ready_all_next;

  always_ff @(posedge clk) begin
    if (rst || s_frame) begin
      ready_all <= '0;
    end else begin
      ready_all <= ready_all_next;
    end
  end

  //////////////////////////////////////////////////
  // channel registers
  //////////////////////////////////////////////////

  // offer only to channels still owed the word
  always_ff @(posedge clk) begin
    if (rst) begin
      m_tvalid <= '0;
    end else if (s_tvalid) begin
      m_tvalid <= ~ready_all_next;
    end else begin
      m_tvalid <= '0;
    end
  end

  // input data is stable until accepted, so reloading holds it
  always_ff @(posedge clk) begin
    for (int n = 0; n < `STREAM_NUM_CHANNELS; n++) begin
      if (!ready_all_next[n]) begin
        m_tdata[n] <= s_tdata;
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  // a channel still offered and not taking blocks acceptance
  a_accept_all: assert property (@(posedge clk) disable iff (rst)
    s_frame |-> ((m_tvalid & ~m_tready) == '0));

  // a delivered channel is never offered the same word again
  a_no_repeat: assert property (@(posedge clk) disable iff (rst)
    (m_tvalid & ready_all) == '0);

endmodule

`default_nettype wire

// File: rtl/axis_fifo_sync.sv
// synchronous stream FIFO
// flop-based storage with wrap-bit pointers and a fill level
// m_tvalid follows the level, m_tdata is read from the
// register array at the read pointer
// a full FIFO still accepts a write in a cycle with a read

`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module axis_fifo_sync #(
  parameter int DEPTH = `STREAM_FIFO_DEPTH
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         s_tvalid,
  output logic                         s_tready,
  input  stream_types_pkg::data_word_t s_tdata,
  output logic                         m_tvalid,
  input  logic                         m_tready,
  output stream_types_pkg::data_word_t m_tdata
);
  import stream_types_pkg::*;
  import fifo_types_pkg::*;

  // index bits, wrap bit sits above them
  localparam int AW = $clog2(DEPTH);

  data_word_t  mem [DEPTH];
  fifo_addr_t  wr_ptr;
  fifo_addr_t  rd_ptr;
  fifo_level_t level;
  logic        wr_en;
  logic        rd_en;

  //////////////////////////////////////////////////
  // handshakes
  //////////////////////////////////////////////////

  assign wr_en = s_tvalid & s_tready;
  assign rd_en = m_tvalid & m_tready;

  // full only blocks when nothing leaves
  assign s_tready = (level != fifo_level_t'(DEPTH)) | m_tready;
  assign m_tvalid = (level != '0);
  assign m_tdata  = mem[rd_ptr[AW-1:0]];

  //////////////////////////////////////////////////
  // pointers and level
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous read and write leaves level alone
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= s_tdata;
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_level_max: assert property (@(posedge clk) disable iff (rst)
    level <= fifo_level_t'(DEPTH));

  // pointers agree the FIFO holds something on every read
  a_no_empty_read: assert property (@(posedge clk) disable iff (rst)
    rd_en |-> (wr_ptr != rd_ptr));

endmodule

`default_nettype wire

// File: rtl/axis_skid_buffer.sv
// input skid buffer
// two-entry register stage on a valid/ready stream
// s_tready and the whole output side come straight from flops,
// a spare register catches the word that lands during a stall

`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         s_tvalid,
  output logic                         s_tready,
  input  stream_types_pkg::data_word_t s_tdata,
  output logic                         m_tvalid,
  input  logic                         m_tready,
  output stream_types_pkg::data_word_t m_tdata
);
  import stream_types_pkg::*;

  logic       spare_valid;
  data_word_t spare_data;
  logic       in_xfer;
  logic       out_free;

  assign in_xfer = s_tvalid & s_tready;
  // main register empty or draining this cycle
  assign out_free = m_tready | ~m_tvalid;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      m_tvalid    <= 1'b0;
      spare_valid <= 1'b0;
      s_tready    <= 1'b1;
    end else if (out_free) begin
      // spare goes first, input is closed while spare is full
      m_tvalid    <= spare_valid | in_xfer;
      spare_valid <= 1'b0;
      s_tready    <= 1'b1;
    end else if (in_xfer) begin
      // stalled with a word arriving, park it
      spare_valid <= 1'b1;
      s_tready    <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (out_free) begin
      if (spare_valid) begin
        m_tdata <= spare_data;
      end else if (in_xfer) begin
        m_tdata <= s_tdata;
      end
    end
    if (in_xfer && !out_free) begin
      spare_data <= s_tdata;
    end
  end

  // stalled output keeps its word
  a_hold_stall: assert property (@(posedge clk) disable iff (rst)
    (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata)));

endmodule

`default_nettype wire

// File: rtl/fifo_types_pkg.sv
// FIFO bookkeeping types
// pointers carry one extra wrap bit so full and empty differ,
// the level counts 0 to depth inclusive

`default_nettype none

`include "stream_defs.svh"

package fifo_types_pkg;

  // read/write pointer, index plus wrap bit
  typedef logic [$clog2(`STREAM_FIFO_DEPTH):0] fifo_addr_t;

  // fill level, needs room for depth itself
  typedef logic [$clog2(`STREAM_FIFO_DEPTH+1)-1:0] fifo_level_t;

endpackage

`default_nettype wire

// File: rtl/stream_types_pkg.sv
// stream payload types
// the data word and the one-bit-per-channel vector used for
// valid, ready and delivered flags

`default_nettype none

`include "stream_defs.svh"

package stream_types_pkg;

  // one payload word
  typedef logic [`STREAM_DATA_WIDTH-1:0] data_word_t;

  // one bit per output channel
  typedef logic [`STREAM_NUM_CHANNELS-1:0] chan_vec_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the broadcast testbench with Verilator
# sim.log decides pass or fail

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f \
  --top-module axis_broadcast_tb -o axis_broadcast_sim > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/axis_broadcast_sim > sim.log 2>&1

grep -q "^ALL CHECKS PASSED$" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// File: tb/axis_broadcast_tb.sv
// broadcast stage testbench
// LFSR stimulus over four phases, per-channel queues as scoreboard,
// concurrent assertions check ordering, hold, latency and drain

`timescale 1ns/1ps
`default_nettype none

`include "stream_defs.svh"

module axis_broadcast_tb;
  import stream_types_pkg::*;

  localparam int NCH = `STREAM_NUM_CHANNELS;
  localparam int DEPTH = `STREAM_FIFO_DEPTH;
  localparam int PHASE_WORDS = 96;
  // four phases, up to ~12 cycles per word, plus margin
  localparam int MAX_CYCLES = 6000;

  logic clk = 1'b0;
  logic rst;
  logic s_tvalid;
  logic s_tready;
  data_word_t s_tdata;
  chan_vec_t m_tvalid;
  chan_vec_t m_tready;
  data_word_t m_tdata [NCH];

  logic [31:0] lfsr = 32'h87a3;
  data_word_t sb_q [NCH][$];
  int q_cnt [NCH];
  data_word_t exp_head [NCH];
  logic all_empty;
  int phase;
  int words_req;
  int words_sent;
  logic stall2;
  logic stall_end;
  int stall_accepts;
  logic drain_check;
  logic [2:0] lat_pipe;
  data_word_t lat_word [3];
  int cycles;

  axis_broadcast_top axis_broadcast_top_i (
    .clk (clk), .rst (rst),
    .s_tvalid (s_tvalid), .s_tready (s_tready), .s_tdata (s_tdata),
    .m_tvalid (m_tvalid), .m_tready (m_tready), .m_tdata (m_tdata)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////////////////
  // failure reporting and random bits
  ////////////////////////////////////////////////////

  task automatic report_mismatch(string sig, logic [31:0] expv, logic [31:0] actv);
    $display("[FAIL] t=%0t %s expected %h got %h", $time, sig, expv, actv);
    $display("CHECKS FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic abort_run(string why);
    $display("error at t=%0t: %s", $time, why);
    $display("CHECKS FAILED");
    $fatal(1, "check failed");
  endtask

  // galois LFSR, one step per bit taken
  function automatic logic [15:0] take_bits(int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      r = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////
  // stimulus driver
  ////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      s_tvalid <= 1'b0;
      s_tdata  <= '0;
      m_tready <= '1;
    end else begin
      // new word only once the previous one was taken
      if (!s_tvalid || s_tready) begin
        if (words_sent < words_req && (phase != 4 || take_bits(1))) begin
          s_tvalid   <= 1'b1;
          s_tdata    <= take_bits(16);
          words_sent <= words_sent + 1;
        end else begin
          s_tvalid <= 1'b0;
        end
      end
      case (phase)
        2:       m_tready <= chan_vec_t'(take_bits(NCH));
        3:       m_tready <= stall2 ? 4'b1011 : '1;
        default: m_tready <= '1;
      endcase
    end
  end

  ////////////////////////////////////////////////////
  // scoreboard
  ////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      abort_run("timeout, stream did not finish within the cycle limit");
    end
    lat_pipe <= {lat_pipe[1:0], s_tvalid && s_tready && all_empty && (phase == 1 || phase == 4)};
    lat_word[0] <= s_tdata;
    lat_word[1] <= lat_word[0];
    lat_word[2] <= lat_word[1];
    stall_accepts <= stall2 ? stall_accepts + (s_tvalid && s_tready) : 0;
    for (int n = 0; n < NCH; n++) begin
      // pop before push, the head belongs to this cycle
      if (!rst && m_tvalid[n] && m_tready[n] && sb_q[n].size() > 0) begin
        void'(sb_q[n].pop_front());
      end
      if (!rst && s_tvalid && s_tready) begin
        sb_q[n].push_back(s_tdata);
      end
      q_cnt[n]    <= sb_q[n].size();
      exp_head[n] <= (sb_q[n].size() > 0) ? sb_q[n][0] : '0;
    end
  end

  always_comb begin
    all_empty = 1'b1;
    for (int n = 0; n < NCH; n++) begin
      if (q_cnt[n] != 0) all_empty = 1'b0;
    end
  end

  ////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge clk) rst |=> (m_tvalid == '0 && s_tready))
    else abort_run("outputs not idle during or right after reset");

  a_stall_bound: assert property (@(posedge clk) disable iff (rst)
    stall2 |-> stall_accepts <= DEPTH + 3)
    else abort_run("input kept accepting while channel 2 was stalled");

  a_drained: assert property (@(posedge clk) disable iff (rst)
    drain_check |-> (m_tvalid == '0 && all_empty))
    else abort_run("queues or outputs not empty after drain");

  for (genvar n = 0; n < NCH; n++) begin : g_chk
    a_not_empty: assert property (@(posedge clk) disable iff (rst)
      (m_tvalid[n] && m_tready[n]) |-> q_cnt[n] != 0)
      else abort_run($sformatf("channel %0d delivered a word never sent", n));
    a_order: assert property (@(posedge clk) disable iff (rst)
      (m_tvalid[n] && m_tready[n]) |-> m_tdata[n] == exp_head[n])
      else report_mismatch($sformatf("m_tdata[%0d]", n), $sampled(exp_head[n]),
                           $sampled(m_tdata[n]));
    a_hold: assert property (@(posedge clk) disable iff (rst)
      (m_tvalid[n] && !m_tready[n]) |=> (m_tvalid[n] && $stable(m_tdata[n])))
      else abort_run($sformatf("channel %0d changed a stalled word", n));
    a_latency: assert property (@(posedge clk) disable iff (rst)
      lat_pipe[2] |-> (m_tvalid[n] && m_tdata[n] == lat_word[2]))
      else report_mismatch($sformatf("m_tdata[%0d] at 3 cycles", n), $sampled(lat_word[2]),
                           $sampled(m_tdata[n]));
    // other channels only hold what channel 2 blocks
    // channel 2 is behind by its full FIFO plus the word held for it
    if (n != 2) begin : g_side
      a_side_drain: assert property (@(posedge clk) disable iff (rst)
        stall_end |-> q_cnt[n] + DEPTH + 1 == q_cnt[2])
        else abort_run($sformatf("channel %0d backlog wrong while channel 2 stalled", n));
    end
  end

  ////////////////////////////////////////////////////
  // phase sequence
  ////////////////////////////////////////////////////

  task automatic run_phase(int p);
    phase     <= p;
    words_req <= words_req + PHASE_WORDS;
    if (p == 3) begin
      stall2 <= 1'b1;
      repeat (40) @(posedge clk);
      stall_end <= 1'b1;
      @(posedge clk);
      stall_end <= 1'b0;
      stall2    <= 1'b0;
    end
    do @(posedge clk); while (words_sent != words_req);
    phase <= 0;
    // input idle, all ready, wait for every queue to empty
    do @(posedge clk); while (!all_empty || s_tvalid);
    repeat (2) @(posedge clk);
    drain_check <= 1'b1;
    @(posedge clk);
    drain_check <= 1'b0;
  endtask

  initial begin
    rst = 1'b1;
    phase = 0;
    words_req = 0;
    words_sent = 0;
    stall2 = 1'b0;
    stall_end = 1'b0;
    drain_check = 1'b0;
    cycles = 0;
    s_tvalid = 1'b0;
    s_tdata = '0;
    m_tready = '1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    for (int p = 1; p <= 4; p++) begin
      run_phase(p);
    end
    repeat (4) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
